// File: source/tlp_pkg.sv
// TLP handler shared widths, field codes, CSR map and bus structs
`default_nettype none

package tlp_pkg;

  localparam int DWORD_W     = 32;
  localparam int BEAT_DWORDS = 8;
  localparam int BEAT_W      = DWORD_W * BEAT_DWORDS;  // 256-bit Avalon-ST beat

  typedef logic [DWORD_W-1:0] dword_t;
  typedef logic [BEAT_W-1:0]  beat_t;
  typedef logic [1:0]         empty_t;       // Empty 64-bit pairs at top of end beat
  typedef logic [15:0]        req_id_t;      // Bus/dev/func
  typedef logic [7:0]         tag_t;
  typedef logic [9:0]         tlp_len_t;     // Length in dwords
  typedef logic [11:0]        byte_count_t;
  typedef logic [3:0]         be_t;
  typedef logic [7:0]         lower_addr_t;

  // Decoded request kind
  typedef enum logic [2:0] {
    KIND_MRD,
    KIND_MRDLK,
    KIND_MWR,
    KIND_CPL,
    KIND_CPLD,
    KIND_UNKNOWN
  } tlp_kind_t;

  // Header field codes
  localparam logic [2:0] FMT_CPL       = 3'b000;  // 3DW no data
  localparam logic [2:0] FMT_CPLD      = 3'b010;  // 3DW with data
  localparam logic [4:0] TYPE_CPL      = 5'b01010;
  localparam logic [2:0] CPL_STATUS_SC = 3'h0;
  localparam logic [2:0] CPL_STATUS_UR = 3'h1;

  // Config bus address carrying bus and device number
  localparam logic [3:0] CFG_ADDR_BUSDEV = 4'hF;

  // CSR map
  localparam int CSR_ADDR_W = 6;
  localparam logic [CSR_ADDR_W-1:0] CSR_ID          = 6'd0;
  localparam logic [CSR_ADDR_W-1:0] CSR_RX_COUNT    = 6'd1;
  localparam logic [CSR_ADDR_W-1:0] CSR_TX_COUNT    = 6'd2;
  localparam logic [CSR_ADDR_W-1:0] CSR_RX_HDR_BASE = 6'd8;   // 8 dwords
  localparam logic [CSR_ADDR_W-1:0] CSR_TX_HDR_BASE = 6'd16;  // 8 dwords
  localparam dword_t                CSR_UNMAPPED    = '1;

  // One streaming beat, same shape for rx and tx
  typedef struct packed {
    beat_t  data;
    empty_t empty;
    logic   sop;
    logic   eop;
    logic   valid;
  } st_beat_t;

  // Decoded state of the TLP in flight
  typedef struct packed {
    tlp_kind_t   kind;
    tag_t        tag;
    req_id_t     req_id;
    lower_addr_t lower_addr;
    tlp_len_t    len;
    logic        is_4dw;
    byte_count_t byte_count;
    logic        is_npr;       // Needs a completion
    logic        is_pr;
    logic        unsupported;
  } tlp_frame_t;

endpackage

`default_nettype wire

// File: source/cfg_id_capture.sv
// Config-bus snoop that holds the endpoint requester ID once enumerated
`default_nettype none
`timescale 1ns/1ps

module cfg_id_capture (
  input  logic              clk,
  input  logic              reset,
  input  logic [3:0]        tl_cfg_add,
  input  tlp_pkg::dword_t   tl_cfg_ctl,
  output tlp_pkg::req_id_t  my_id,
  output logic              id_valid
);
  import tlp_pkg::*;

  logic busdev_wr;

  assign busdev_wr = (tl_cfg_add == CFG_ADDR_BUSDEV);

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (busdev_wr) begin
      id_valid <= 1'b1;
    end
  end

  // Bus[7:0] and device[4:0] sit in the low 13 bits, function forced to 0
  always_ff @(posedge clk) begin
    if (busdev_wr) begin
      my_id <= {tl_cfg_ctl[12:0], 3'b000};
    end
  end

  // Once enumerated the ID stays valid until the next reset
  a_id_sticky: assert property (@(posedge clk) !reset && id_valid |=> id_valid);

endmodule

`default_nettype wire

// File: source/tlp_byte_count.sv
// Byte count of a memory request from its length and first/last byte enables
`default_nettype none
`timescale 1ns/1ps

module tlp_byte_count (
  input  tlp_pkg::tlp_len_t    len,
  input  tlp_pkg::be_t         first_be,
  input  tlp_pkg::be_t         last_be,
  output tlp_pkg::byte_count_t byte_count
);
  import tlp_pkg::*;

  // Position of lowest enabled byte
  function automatic logic [1:0] low_idx(be_t be);
    logic [1:0] idx;
    casez (be)
      4'b???1: idx = 2'd0;
      4'b??10: idx = 2'd1;
      4'b?100: idx = 2'd2;
      default: idx = 2'd3;
    endcase
    return idx;
  endfunction

  // Position of highest enabled byte
  function automatic logic [1:0] high_idx(be_t be);
    logic [1:0] idx;
    casez (be)
      4'b1???: idx = 2'd3;
      4'b01??: idx = 2'd2;
      4'b001?: idx = 2'd1;
      default: idx = 2'd0;
    endcase
    return idx;
  endfunction

  byte_count_t full_bytes;   // Whole payload in bytes
  byte_count_t head_skip;    // Disabled bytes below first_be
  byte_count_t tail_skip;    // Disabled bytes above last_be
  byte_count_t span;         // Single-dword span within first_be

  assign full_bytes = {len, 2'b00};
  assign head_skip  = byte_count_t'(low_idx(first_be));
  assign tail_skip  = byte_count_t'(2'd3 - high_idx(last_be));
  assign span       = byte_count_t'(high_idx(first_be)) - head_skip + 12'd1;

  always_comb begin
    if (last_be == 4'h0) begin
      // Single dword request
      if (first_be == 4'h0) begin
        byte_count = 12'd1;             // Zero-length read still counts 1
      end else begin
        byte_count = span;
      end
    end else if (first_be == 4'h0) begin
      byte_count = '0;                  // Illegal enable combination
    end else begin
      byte_count = full_bytes - head_skip - tail_skip;
    end
  end

endmodule

`default_nettype wire

// File: source/tlp_rx_decode.sv
// Receive header decoder that classifies each TLP and flags unsupported requests
`default_nettype none
`timescale 1ns/1ps

module tlp_rx_decode (
  input  logic                clk,
  input  logic                reset,
  input  tlp_pkg::st_beat_t   rx_st,
  input  logic                rx_ready,
  output tlp_pkg::tlp_frame_t frame,
  output logic                frame_start,
  output logic                frame_end,
  output logic                ur_posted,
  output logic                ur_nonposted
);
  import tlp_pkg::*;

  dword_t [BEAT_DWORDS-1:0] dw;
  logic [2:0]  fmt;
  logic [4:0]  typ;
  tlp_kind_t   kind;
  byte_count_t bc;
  logic        accept;
  logic        start_acc;

  // Registered frame
  tlp_kind_t   kind_q;
  tag_t        tag_q;
  req_id_t     req_id_q;
  lower_addr_t addr_q;
  tlp_len_t    len_q;
  logic        is_4dw_q;
  byte_count_t bc_q;
  logic        npr_q;
  logic        pr_q;
  logic        unsup;

  assign dw        = rx_st.data;
  assign fmt       = dw[0][31:29];
  assign typ       = dw[0][28:24];
  assign accept    = rx_st.valid && rx_ready;   // Beat actually taken
  assign start_acc = accept && rx_st.sop;

  always_comb begin
    case ({fmt[1], typ})
      6'b000000: kind = KIND_MRD;
      6'b000001: kind = KIND_MRDLK;
      6'b100000: kind = KIND_MWR;
      6'b001010: kind = KIND_CPL;
      6'b101010: kind = KIND_CPLD;
      default:   kind = KIND_UNKNOWN;
    endcase
  end

  tlp_byte_count i_byte_count (
    .len       (dw[0][9:0]),
    .first_be  (dw[1][3:0]),
    .last_be   (dw[1][7:4]),
    .byte_count(bc)
  );

  always_ff @(posedge clk) begin
    if (start_acc) begin
      kind_q   <= kind;
      len_q    <= dw[0][9:0];
      is_4dw_q <= fmt[0];
      bc_q     <= bc;
      if (kind == KIND_CPL || kind == KIND_CPLD) begin
        tag_q    <= dw[2][15:8];    // Completion keeps IDs in h2
        req_id_q <= dw[2][31:16];
      end else begin
        tag_q    <= dw[1][15:8];
        req_id_q <= dw[1][31:16];
      end
      addr_q <= fmt[0] ? {dw[3][7:2], 2'b00} : {dw[2][7:2], 2'b00};
      npr_q  <= 1'b0;
      pr_q   <= 1'b0;
      casez ({fmt[1], typ})
        6'b00000?: npr_q <= 1'b1;   // MRd, MRdLk
        6'b?00010: npr_q <= 1'b1;   // IO read/write
        6'b1011??: npr_q <= 1'b1;   // AtomicOp
        6'b100000: pr_q  <= 1'b1;   // MWr
        6'b?10???: pr_q  <= 1'b1;   // Msg, MsgD
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end else begin
      frame_start <= start_acc;
      frame_end   <= accept && rx_st.eop;
    end
  end

  // Only 3DW single-dword memory accesses are served
  always_comb begin
    unsup = 1'b0;
    if (kind_q == KIND_UNKNOWN || kind_q == KIND_CPL || kind_q == KIND_MRDLK) begin
      unsup = 1'b1;
    end else if (is_4dw_q) begin
      unsup = 1'b1;                 // No 64-bit addressing
    end else if (kind_q == KIND_MRD || kind_q == KIND_MWR) begin
      unsup = (len_q != 10'd1) || (bc_q != 12'd0 && bc_q != 12'd4);
    end
  end

  assign frame = '{kind: kind_q, tag: tag_q, req_id: req_id_q, lower_addr: addr_q,
                   len: len_q, is_4dw: is_4dw_q, byte_count: bc_q,
                   is_npr: npr_q, is_pr: pr_q, unsupported: unsup};

  assign ur_nonposted = frame_start && unsup && npr_q;
  assign ur_posted    = frame_start && unsup && pr_q;

  // Posted and non-posted error reports are exclusive
  a_ur_onehot: assert property (@(posedge clk) disable iff (reset)
    frame_start && frame.unsupported |-> !(ur_posted && ur_nonposted));

endmodule

`default_nettype wire

// File: source/cpl_builder.sv
// Completion generator emitting one-beat CplD or UR replies for non-posted TLPs
`default_nettype none
`timescale 1ns/1ps

module cpl_builder (
  input  logic                clk,
  input  logic                reset,
  input  tlp_pkg::tlp_frame_t frame,
  input  logic                frame_end,
  input  tlp_pkg::req_id_t    my_id,
  output tlp_pkg::st_beat_t   tx_st
);
  import tlp_pkg::*;

  dword_t [BEAT_DWORDS-1:0] dw;
  empty_t empty;
  dword_t data_dw;
  logic   fire;
  logic   is_ur;
  logic   valid_q;
  beat_t  data_q;
  empty_t empty_q;

  assign fire    = frame_end && frame.is_npr;
  assign is_ur   = frame.unsupported || (frame.kind != KIND_MRD);
  assign data_dw = {frame.tag, frame.req_id, frame.lower_addr};   // Echo pattern

  always_comb begin
    dw    = '0;
    empty = 2'd2;
    dw[0][28:24] = TYPE_CPL;
    dw[1][31:16] = my_id;                                          // Completer ID
    dw[2] = {frame.req_id, frame.tag, 1'b0, frame.lower_addr[6:0]};
    if (is_ur) begin
      dw[0][31:29] = FMT_CPL;
      dw[0][9:0]   = 10'd0;
      dw[1][15:13] = CPL_STATUS_UR;
      dw[1][11:0]  = frame.byte_count;
    end else begin
      dw[0][31:29] = FMT_CPLD;
      dw[0][9:0]   = 10'd1;
      dw[1][15:13] = CPL_STATUS_SC;
      dw[1][11:0]  = 12'd4;
      // Qword-aligned address needs a pad dword after the header
      if (!frame.lower_addr[2]) begin
        dw[4] = data_dw;
        empty = 2'd1;
      end else begin
        dw[3] = data_dw;
        empty = 2'd2;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      data_q  <= dw;
      empty_q <= empty;
    end
  end

  // Every completion is a single beat
  assign tx_st = '{data: data_q, empty: empty_q, sop: valid_q, eop: valid_q, valid: valid_q};

  a_single_beat: assert property (@(posedge clk) disable iff (reset)
    tx_st.valid |-> tx_st.sop && tx_st.eop);

endmodule

`default_nettype wire

// File: source/tlp_stats_csr.sv
// TLP statistics with masked last-header copies behind a read-only CSR port
`default_nettype none
`timescale 1ns/1ps

module tlp_stats_csr (
  input  logic                            clk,
  input  logic                            reset,
  input  tlp_pkg::st_beat_t               rx_st,
  input  logic                            rx_ready,
  input  tlp_pkg::st_beat_t               tx_st,
  input  tlp_pkg::req_id_t                my_id,
  input  logic                            csr_read,
  input  logic [tlp_pkg::CSR_ADDR_W-1:0]  csr_address,
  output tlp_pkg::dword_t                 csr_readdata
);
  import tlp_pkg::*;

  localparam int SEL_W = $clog2(BEAT_DWORDS);

  // Start beat copy with the empty top dwords forced to ones
  function automatic beat_t masked_copy(st_beat_t b);
    beat_t r;
    int    keep;
    r    = b.data;
    keep = BEAT_DWORDS - 2 * int'(b.empty);
    if (b.eop) begin
      for (int i = 0; i < BEAT_DWORDS; i++) begin
        if (i >= keep) begin
          r[i*DWORD_W +: DWORD_W] = '1;
        end
      end
    end
    return r;
  endfunction

  logic             rx_take;
  logic             tx_take;
  dword_t           rx_count;
  dword_t           tx_count;
  beat_t            rx_hdr;
  beat_t            tx_hdr;
  logic [SEL_W-1:0] hdr_sel;

  assign rx_take = rx_st.valid && rx_ready && rx_st.sop;
  assign tx_take = tx_st.valid && tx_st.sop;
  assign hdr_sel = csr_address[SEL_W-1:0];   // Header windows are 8-aligned

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_count <= '0;
      tx_count <= '0;
      rx_hdr   <= '0;
      tx_hdr   <= '0;
    end else begin
      if (rx_take) begin
        rx_count <= rx_count + 32'd1;
        rx_hdr   <= masked_copy(rx_st);
      end
      if (tx_take) begin
        tx_count <= tx_count + 32'd1;
        tx_hdr   <= masked_copy(tx_st);
      end
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge clk) begin
    if (csr_read) begin
      if (csr_address == CSR_ID) begin
        csr_readdata <= dword_t'(my_id);
      end else if (csr_address == CSR_RX_COUNT) begin
        csr_readdata <= rx_count;
      end else if (csr_address == CSR_TX_COUNT) begin
        csr_readdata <= tx_count;
      end else if (csr_address inside {[CSR_RX_HDR_BASE : CSR_RX_HDR_BASE + 6'd7]}) begin
        csr_readdata <= rx_hdr[hdr_sel*DWORD_W +: DWORD_W];
      end else if (csr_address inside {[CSR_TX_HDR_BASE : CSR_TX_HDR_BASE + 6'd7]}) begin
        csr_readdata <= tx_hdr[hdr_sel*DWORD_W +: DWORD_W];
      end else begin
        csr_readdata <= CSR_UNMAPPED;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/tlp_handler_top.sv
// PCIe endpoint TLP handler joining decode, completion, config snoop and CSRs
`default_nettype none
`timescale 1ns/1ps

module tlp_handler_top (
  input  logic                           clk,
  input  logic                           reset,
  input  tlp_pkg::st_beat_t              rx_st,
  output logic                           rx_st_ready,
  output tlp_pkg::st_beat_t              tx_st,
  input  logic [3:0]                     tl_cfg_add,
  input  tlp_pkg::dword_t                tl_cfg_ctl,
  output logic                           ur_posted,
  output logic                           ur_nonposted,
  input  logic                           csr_read,
  input  logic [tlp_pkg::CSR_ADDR_W-1:0] csr_address,
  output tlp_pkg::dword_t                csr_readdata
);
  import tlp_pkg::*;

  req_id_t    my_id;
  logic       id_valid;
  tlp_frame_t frame;
  logic       frame_end;

  // Accept traffic only once the requester ID is known
  assign rx_st_ready = !reset && id_valid;

  cfg_id_capture i_cfg_id_capture (
    .clk       (clk),
    .reset     (reset),
    .tl_cfg_add(tl_cfg_add),
    .tl_cfg_ctl(tl_cfg_ctl),
    .my_id     (my_id),
    .id_valid  (id_valid)
  );

  tlp_rx_decode i_tlp_rx_decode (
    .clk         (clk),
    .reset       (reset),
    .rx_st       (rx_st),
    .rx_ready    (rx_st_ready),
    .frame       (frame),
    .frame_start (),              // Consumed inside decode for error pulses
    .frame_end   (frame_end),
    .ur_posted   (ur_posted),
    .ur_nonposted(ur_nonposted)
  );

  cpl_builder i_cpl_builder (
    .clk      (clk),
    .reset    (reset),
    .frame    (frame),
    .frame_end(frame_end),
    .my_id    (my_id),
    .tx_st    (tx_st)
  );

  tlp_stats_csr i_tlp_stats_csr (
    .clk         (clk),
    .reset       (reset),
    .rx_st       (rx_st),
    .rx_ready    (rx_st_ready),
    .tx_st       (tx_st),
    .my_id       (my_id),
    .csr_read    (csr_read),
    .csr_address (csr_address),
    .csr_readdata(csr_readdata)
  );

endmodule

`default_nettype wire

// File: dv/tb_tlp_handler.sv
// Testbench for the TLP handler checking completions, error pulses and CSRs by reference rules
`default_nettype none
`timescale 1ns/1ps

module tb_tlp_handler;
  import tlp_pkg::*;

  localparam int TIMEOUT_CYCLES = 3000;  // Well beyond the stimulus length

  // Expected DUT responses launched with the stimulus and delayed to match latency
  typedef struct packed {
    logic   tx_valid;
    beat_t  tx_data;
    empty_t tx_empty;
    logic   ur_p;
    logic   ur_np;
    logic   csr_chk;
    dword_t csr_data;
  } expect_t;

  logic                  clk;
  logic                  reset;
  st_beat_t              rx_st;
  logic                  rx_st_ready;
  st_beat_t              tx_st;
  logic [3:0]            tl_cfg_add;
  dword_t                tl_cfg_ctl;
  logic                  ur_posted;
  logic                  ur_nonposted;
  logic                  csr_read;
  logic [CSR_ADDR_W-1:0] csr_address;
  dword_t                csr_readdata;

  integer  seed;
  int      cycle_count;
  logic    cfg_seen;        // Bus/device write already sampled by the DUT
  expect_t exp0;            // Drive stage
  expect_t exp1;            // One cycle after the accepting edge
  expect_t exp2;            // Two cycles after
  req_id_t model_id;
  dword_t  model_rx_count;
  dword_t  model_tx_count;
  beat_t   model_rx_hdr;
  beat_t   model_tx_hdr;

  tlp_handler_top i_tlp_handler_top (
    .clk         (clk),
    .reset       (reset),
    .rx_st       (rx_st),
    .rx_st_ready (rx_st_ready),
    .tx_st       (tx_st),
    .tl_cfg_add  (tl_cfg_add),
    .tl_cfg_ctl  (tl_cfg_ctl),
    .ur_posted   (ur_posted),
    .ur_nonposted(ur_nonposted),
    .csr_read    (csr_read),
    .csr_address (csr_address),
    .csr_readdata(csr_readdata)
  );

  always #10 clk = ~clk;  // 20 ns period

  task automatic abort_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // PCIe byte count table from the spec rules
  function automatic byte_count_t ref_byte_count(tlp_len_t len, be_t fbe, be_t lbe);
    int lo;
    int hi;
    int hz;
    logic seen;
    lo = -1;
    hi = -1;
    for (int i = 0; i < 4; i++) begin
      if (fbe[i]) begin
        if (lo < 0) lo = i;
        hi = i;
      end
    end
    hz = 0;
    seen = 1'b0;
    for (int i = 3; i >= 0; i--) begin
      if (lbe[i]) seen = 1'b1;
      else if (!seen) hz++;           // Disabled bytes above the top enable
    end
    if (lbe == 4'h0) return (fbe == 4'h0) ? 12'd1 : byte_count_t'(hi - lo + 1);
    if (fbe == 4'h0) return 12'd0;
    return byte_count_t'(4 * int'(len) - lo - hz);
  endfunction

  // Top empty pairs of a single-beat packet read back as ones
  function automatic beat_t mask_top(beat_t b, empty_t emp);
    for (int i = 0; i < BEAT_DWORDS; i++) begin
      if (i >= BEAT_DWORDS - 2 * int'(emp)) b[i*DWORD_W +: DWORD_W] = '1;
    end
    return b;
  endfunction

  // One single-beat request; a2 sets address bit 2
  task automatic send_tlp(input logic [2:0] fmt, input logic [4:0] typ, input tlp_len_t len,
                          input be_t fbe, input be_t lbe, input logic a2);
    beat_t       d;
    beat_t       c;
    dword_t      r;
    tag_t        tag;
    req_id_t     rid;
    lower_addr_t addr;
    byte_count_t bc;
    empty_t      emp;
    empty_t      cemp;
    expect_t     e;
    int          used;
    logic        mrd;
    logic        mrdlk;
    logic        mwr;
    logic        unsup;
    for (int i = 0; i < BEAT_DWORDS; i++) d[i*DWORD_W +: DWORD_W] = $random(seed);
    r    = $random(seed);
    tag  = r[7:0];
    rid  = r[23:8];
    addr = {r[31:27], a2, 2'b00};
    d[31:0]  = {fmt, typ, 14'd0, len};
    d[63:32] = {rid, tag, lbe, fbe};
    r = $random(seed);
    if (fmt[0]) d[127:96] = {r[31:8], addr};  // 64-bit address with the low dword last
    else d[95:64] = {r[31:8], addr};
    used = (fmt[0] ? 4 : 3) + (fmt[1] ? int'(len) : 0);
    if (used > BEAT_DWORDS) used = BEAT_DWORDS;
    emp = empty_t'((BEAT_DWORDS - used) / 2);
    bc    = ref_byte_count(len, fbe, lbe);
    mrd   = !fmt[1] && typ == 5'b00000;
    mrdlk = !fmt[1] && typ == 5'b00001;
    mwr   = fmt[1] && typ == 5'b00000;
    unsup = mrdlk || fmt[0] || ((mrd || mwr) && (len != 10'd1 || (bc != 12'd0 && bc != 12'd4)));
    e = '0;
    e.ur_np = unsup && (mrd || mrdlk);
    e.ur_p  = unsup && mwr;
    if (mrd || mrdlk) begin
      c = '0;
      cemp = 2'd2;
      c[95:64] = {rid, tag, 1'b0, addr[6:0]};
      if (unsup) begin
        c[31:0]  = {FMT_CPL, TYPE_CPL, 14'd0, 10'd0};
        c[63:32] = {model_id, CPL_STATUS_UR, 1'b0, bc};
      end else begin
        c[31:0]  = {FMT_CPLD, TYPE_CPL, 14'd0, 10'd1};
        c[63:32] = {model_id, CPL_STATUS_SC, 1'b0, 12'd4};
        if (addr[2]) begin
          c[127:96] = {tag, rid, addr};
        end else begin
          c[159:128] = {tag, rid, addr};  // Pad dword keeps qword alignment
          cemp = 2'd1;
        end
      end
      e.tx_valid = 1'b1;
      e.tx_data  = c;
      e.tx_empty = cemp;
      model_tx_count = model_tx_count + 32'd1;
      model_tx_hdr   = mask_top(c, cemp);
    end
    model_rx_count = model_rx_count + 32'd1;
    model_rx_hdr   = mask_top(d, emp);
    @(negedge clk);
    rx_st = '{data: d, empty: emp, sop: 1'b1, eop: 1'b1, valid: 1'b1};
    exp0  = e;
    @(negedge clk);
    rx_st.valid = 1'b0;
    rx_st.sop   = 1'b0;
    rx_st.eop   = 1'b0;
    exp0 = '0;
  endtask

  task automatic cfg_write(input logic [3:0] addr);
    @(negedge clk);
    tl_cfg_add = addr;
    tl_cfg_ctl = $random(seed);
    if (addr == CFG_ADDR_BUSDEV) model_id = {tl_cfg_ctl[12:0], 3'b000};
    @(negedge clk);
    tl_cfg_add = 4'h0;
    if (addr == CFG_ADDR_BUSDEV) cfg_seen = 1'b1;
  endtask

  task automatic csr_check(input logic [CSR_ADDR_W-1:0] addr, input dword_t expected);
    @(negedge clk);
    csr_read      = 1'b1;
    csr_address   = addr;
    exp0.csr_chk  = 1'b1;
    exp0.csr_data = expected;
    @(negedge clk);
    csr_read = 1'b0;
    exp0     = '0;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      exp1 <= '0;
      exp2 <= '0;
    end else begin
      exp1 <= exp0;
      exp2 <= exp1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) abort_run("Timeout, the stimulus did not complete");
  end

  // Receive opens exactly one cycle after the bus/device write
  a_ready: assert property (@(posedge clk) rx_st_ready == cfg_seen)
    else abort_run($sformatf("Mismatch at %0t: rx_st_ready level wrong", $time));
  a_ur_np: assert property (@(posedge clk) disable iff (reset) ur_nonposted == exp1.ur_np)
    else abort_run($sformatf("Mismatch at %0t: ur_nonposted pulse wrong", $time));
  a_ur_p: assert property (@(posedge clk) disable iff (reset) ur_posted == exp1.ur_p)
    else abort_run($sformatf("Mismatch at %0t: ur_posted pulse wrong", $time));
  a_tx_valid: assert property (@(posedge clk) disable iff (reset) tx_st.valid == exp2.tx_valid)
    else abort_run($sformatf("Mismatch at %0t: tx_st valid wrong", $time));
  a_tx_beat: assert property (@(posedge clk) disable iff (reset)
    exp2.tx_valid |-> tx_st.sop && tx_st.eop && tx_st.data == exp2.tx_data
                      && tx_st.empty == exp2.tx_empty)
    else abort_run($sformatf("Mismatch at %0t: completion beat contents wrong", $time));
  a_csr: assert property (@(posedge clk) disable iff (reset)
    exp1.csr_chk |-> csr_readdata == exp1.csr_data)
    else abort_run($sformatf("Mismatch at %0t: csr_readdata wrong", $time));

  initial begin
    dword_t r;
    seed = 32'hf884_007e;
    clk = 1'b0;
    reset = 1'b1;
    rx_st = '0;
    tl_cfg_add = 4'h0;
    tl_cfg_ctl = '0;
    csr_read = 1'b0;
    csr_address = '0;
    cycle_count = 0;
    cfg_seen = 1'b0;
    exp0 = '0;
    model_id = '0;
    model_rx_count = '0;
    model_tx_count = '0;
    model_rx_hdr = '0;
    model_tx_hdr = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (8) @(negedge clk);
    cfg_write(4'h2);                    // Other config registers leave receive closed
    repeat (4) @(negedge clk);
    cfg_write(CFG_ADDR_BUSDEV);
    csr_check(CSR_ID, dword_t'(model_id));
    // Supported reads, both data placements
    for (int i = 0; i < 8; i++) send_tlp(3'b000, 5'b00000, 10'd1, 4'hF, 4'h0, i[0]);
    // Unsupported non-posted
    r = $random(seed);
    send_tlp(3'b000, 5'b00000, 10'd2, 4'hF, 4'hF, r[0]);
    send_tlp(3'b001, 5'b00000, 10'd1, 4'hF, 4'h0, r[1]);
    send_tlp(3'b000, 5'b00001, 10'd1, 4'hF, 4'h0, r[2]);
    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      send_tlp(3'b000, 5'b00000, 10'd1, {1'b0, r[2:0]}, 4'h0, r[3]);
    end
    // Posted writes
    send_tlp(3'b010, 5'b00000, 10'd1, 4'hF, 4'h0, r[4]);
    send_tlp(3'b010, 5'b00000, 10'd2, 4'hF, 4'hF, r[5]);
    repeat (4) @(negedge clk);
    csr_check(CSR_RX_COUNT, model_rx_count);
    csr_check(CSR_TX_COUNT, model_tx_count);
    for (int i = 0; i < BEAT_DWORDS; i++) begin
      csr_check(CSR_RX_HDR_BASE + 6'(i), model_rx_hdr[i*DWORD_W +: DWORD_W]);
      csr_check(CSR_TX_HDR_BASE + 6'(i), model_tx_hdr[i*DWORD_W +: DWORD_W]);
    end
    csr_check(6'd3, CSR_UNMAPPED);
    csr_check(6'd24, CSR_UNMAPPED);
    csr_check(6'd63, CSR_UNMAPPED);
    repeat (3) @(negedge clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
source/tlp_pkg.sv
source/cfg_id_capture.sv
source/tlp_byte_count.sv
source/tlp_rx_decode.sv
source/cpl_builder.sv
source/tlp_stats_csr.sv
source/tlp_handler_top.sv
dv/tb_tlp_handler.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_tlp_handler -o sim_tlp &&
./obj_dir/sim_tlp | tee /dev/stderr | grep -q '^>>> PASS$' &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }
